/* test/avl_stimulus.txt */
# port addr wdata strb exp_rdata exp_err iaddr iexp (hex; I uses addr, B adds the fetch in iaddr)
# Port D is the data port, I the instruction port, B both at once
D 00000010 11223344 f 00000000 0 00000000 00000000
D 00000010 00000000 0 11223344 0 00000000 00000000
D 00000024 a5a5f00f f 00000000 0 00000000 00000000
D 00000024 00000000 0 a5a5f00f 0 00000000 00000000
D 00000038 deadbeef f 00000000 0 00000000 00000000
D 00000038 00000000 0 deadbeef 0 00000000 00000000
D 0000003c 0badcafe f 00000000 0 00000000 00000000
D 0000003c 00000000 0 0badcafe 0 00000000 00000000
D 00000040 11111111 f 00000000 0 00000000 00000000
D 00000040 aabbccdd 1 00000000 0 00000000 00000000
D 00000040 22334455 6 00000000 0 00000000 00000000
D 00000040 99000000 8 00000000 0 00000000 00000000
I 00000040 00000000 0 993344dd 0 00000000 00000000
D 00000040 00000000 0 993344dd 0 00000000 00000000
D 00000410 ffffffff f 00000000 1 00000000 00000000
D 00000400 00000000 0 00000000 1 00000000 00000000
D 00000010 00000000 0 11223344 0 00000000 00000000
I 00000800 00000000 0 00000000 1 00000000 00000000
B 00000024 00000000 0 a5a5f00f 0 00000038 deadbeef
B 00000050 12345678 f 00000000 0 00000010 11223344
D 00000050 00000000 0 12345678 0 00000000 00000000
B 0000003c 00000000 0 0badcafe 0 00000040 993344dd
B 00000410 00000000 0 00000000 1 00000024 a5a5f00f

/* tb.f */
rtl/avl_pkg.sv
rtl/mem_port_arbiter.sv
rtl/avl_bridge.sv
rtl/avl_ram_slave.sv
rtl/avl_subsystem.sv
test/tb_avl_subsystem.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_avl_subsystem -f tb.f -o tb_sim

./obj_dir/tb_sim > sim.log 2>&1
cat sim.log

if grep -q "STATUS: FAIL" sim.log; then
  echo "Simulation failed, see sim.log"
  exit 1
fi
if ! grep -q "STATUS: PASS" sim.log; then
  echo "Simulation ended without a pass status, see sim.log"
  exit 1
fi
echo "Simulation passed"

/* test/tb_avl_subsystem.sv */
`timescale 1ns/1ps

module tb_avl_subsystem;

  localparam int MAX_OPS = 64;

  logic              m_avl_hclk;
  logic              m_avl_hresetn;
  logic              ifetch_valid;
  logic [31:0]       ifetch_addr;
  logic              ifetch_done;
  avl_pkg::mem_rsp_t ifetch_rsp;
  logic              data_valid;
  avl_pkg::mem_req_t data_req;
  logic              data_done;
  avl_pkg::mem_rsp_t data_rsp;

  string       op_port  [MAX_OPS];
  logic [31:0] op_addr  [MAX_OPS];
  logic [31:0] op_wdata [MAX_OPS];
  logic [3:0]  op_strb  [MAX_OPS];
  logic [31:0] op_rdata [MAX_OPS];
  logic        op_err   [MAX_OPS];
  logic [31:0] op_iaddr [MAX_OPS];
  logic [31:0] op_iexp  [MAX_OPS];

  int          n_ops = 0;
  int          err_count = 0;
  int          pass_count = 0;
  int          fail_count = 0;
  int          cycle_cnt = 0;
  int          cycle_limit = 1000;
  logic [31:0] lfsr;
  logic        last_was_data;  // Model of which port the arbiter served last

  avl_subsystem u_dut (
    .m_avl_hclk, .m_avl_hresetn,
    .ifetch_valid, .ifetch_addr, .ifetch_done, .ifetch_rsp,
    .data_valid, .data_req, .data_done, .data_rsp
  );

  initial m_avl_hclk = 1'b0;
  always #20 m_avl_hclk = ~m_avl_hclk;

  always @(posedge m_avl_hclk) begin
    cycle_cnt++;
    if (cycle_cnt >= cycle_limit) begin
      $display("Timeout: a transfer did not complete within %0d cycles", cycle_limit);
      $display("STATUS: FAIL");
      $finish;
    end
  end

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  // Two LFSR steps give an idle gap of 0 to 3 cycles
  task automatic random_gap(output int gap);
    gap = 0;
    for (int b = 0; b < 2; b++) begin
      lfsr = lfsr_next(lfsr);
      gap  = gap * 2 + int'(lfsr[0]);
    end
  endtask

  task automatic check_val(input string name, input logic [31:0] got,
                           input logic [31:0] exp);
    if (got !== exp) begin
      $display("FAILED %s: got 0x%08h, expected 0x%08h", name, got, exp);
      err_count++;
    end
  endtask

  task automatic check_idle(input int cycles);
    repeat (cycles) begin
      @(negedge m_avl_hclk);
      check_val("ifetch_done", 32'(ifetch_done), 32'd0);
      check_val("data_done", 32'(data_done), 32'd0);
    end
  endtask

  task automatic load_stimulus();
    int          fd;
    string       line;
    string       port;
    logic [31:0] a, w, s, r, e, ia, ie;
    fd = $fopen("test/avl_stimulus.txt", "r");
    if (fd == 0) begin
      $display("Could not open the stimulus file test/avl_stimulus.txt");
      err_count++;
      return;
    end
    while (!$feof(fd) && n_ops < MAX_OPS) begin
      if ($fgets(line, fd) != 0 && line.len() > 0 && line[0] != "#") begin
        if ($sscanf(line, "%s %h %h %h %h %h %h %h", port, a, w, s, r, e, ia, ie) == 8) begin
          op_port[n_ops]  = port;
          op_addr[n_ops]  = a;
          op_wdata[n_ops] = w;
          op_strb[n_ops]  = s[3:0];
          op_rdata[n_ops] = r;
          op_err[n_ops]   = e[0];
          op_iaddr[n_ops] = ia;
          op_iexp[n_ops]  = ie;
          n_ops++;
        end
      end
    end
    $fclose(fd);
  endtask

  task automatic run_op(input int i);
    bit          want_d, want_i, first_data, first_set;
    int          n_d, n_i;
    logic [31:0] i_exp;
    logic        i_err;
    want_d     = (op_port[i] != "I");
    want_i     = (op_port[i] != "D");
    n_d        = 0;
    n_i        = 0;
    first_data = 1'b0;
    first_set  = 1'b0;
    i_exp      = (op_port[i] == "I") ? op_rdata[i] : op_iexp[i];
    i_err      = (op_port[i] == "I") ? op_err[i] : 1'b0;
    if (want_d) begin
      data_req.addr  = op_addr[i];
      data_req.wdata = op_wdata[i];
      data_req.strb  = op_strb[i];
      data_req.instr = 1'b0;
      data_valid     = 1'b1;
    end
    if (want_i) begin
      ifetch_addr  = (op_port[i] == "I") ? op_addr[i] : op_iaddr[i];
      ifetch_valid = 1'b1;
    end
    while ((want_d && n_d == 0) || (want_i && n_i == 0)) begin
      @(negedge m_avl_hclk);
      if (data_done) begin
        n_d++;
        check_val("data_rsp.rdata", data_rsp.rdata, op_rdata[i]);
        check_val("data_rsp.err", 32'(data_rsp.err), 32'(op_err[i]));
        data_valid = 1'b0;
        if (!first_set) begin
          first_data = 1'b1;
          first_set  = 1'b1;
        end
      end
      if (ifetch_done) begin
        n_i++;
        check_val("ifetch_rsp.rdata", ifetch_rsp.rdata, i_exp);
        check_val("ifetch_rsp.err", 32'(ifetch_rsp.err), 32'(i_err));
        ifetch_valid = 1'b0;
        first_set    = 1'b1;
      end
    end
    check_val("data_done count", 32'(n_d), 32'(want_d));
    check_val("ifetch_done count", 32'(n_i), 32'(want_i));
    // In a tie the port not served last goes first, the other one follows
    if (want_d && want_i) begin
      check_val("first done is data", 32'(first_data), 32'(!last_was_data));
      last_was_data = !first_data;
    end else begin
      last_was_data = want_d;
    end
  endtask

  initial begin
    int gap;
    int errs_before;
    m_avl_hresetn = 1'b0;
    ifetch_valid  = 1'b0;
    ifetch_addr   = 32'd0;
    data_valid    = 1'b0;
    data_req      = '0;
    last_was_data = 1'b0;
    lfsr          = 32'ha577_b2c2;
    load_stimulus();
    cycle_limit = (n_ops > 0) ? n_ops * 20 : 20;
    repeat (4) @(posedge m_avl_hclk);
    @(negedge m_avl_hclk);
    m_avl_hresetn = 1'b1;
    check_idle(4); // No done pulse may appear without a request

    for (int i = 0; i < n_ops; i++) begin
      random_gap(gap);
      check_idle(gap);
      errs_before = err_count;
      run_op(i);
      if (err_count == errs_before) pass_count++;
      else fail_count++;
      $display("test %0d %s addr 0x%08h %s", i + 1, op_port[i], op_addr[i],
               (err_count == errs_before) ? "passed" : "failed");
    end
    check_idle(2);

    $display("tests: %0d, passed: %0d, failed: %0d, errors: %0d",
             n_ops, pass_count, fail_count, err_count);
    if (err_count == 0 && n_ops > 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

/* rtl/avl_subsystem.sv */
`timescale 1ns/1ps

module avl_subsystem (
  input  logic              m_avl_hclk,
  input  logic              m_avl_hresetn,
  input  logic              ifetch_valid,
  input  logic [31:0]       ifetch_addr,
  output logic              ifetch_done,
  output avl_pkg::mem_rsp_t ifetch_rsp,
  input  logic              data_valid,
  input  avl_pkg::mem_req_t data_req,
  output logic              data_done,
  output avl_pkg::mem_rsp_t data_rsp
);

  logic              br_valid;
  avl_pkg::mem_req_t br_req;
  logic              br_done;
  avl_pkg::mem_rsp_t br_rsp;

  logic [31:0] avl_address;
  logic [3:0]  avl_byteenable;
  logic        avl_read;
  logic        avl_write;
  logic [31:0] avl_writedata;
  logic        avl_waitrequest;
  logic [31:0] avl_readdata;
  logic        avl_readdatavalid;
  logic        avl_writeresponsevalid;
  logic [1:0]  avl_response;

  mem_port_arbiter u_arbiter (
    .m_avl_hclk, .m_avl_hresetn,
    .ifetch_valid, .ifetch_addr, .ifetch_done, .ifetch_rsp,
    .data_valid, .data_req, .data_done, .data_rsp,
    .br_valid, .br_req, .br_done, .br_rsp
  );

  avl_bridge u_bridge (
    .m_avl_hclk, .m_avl_hresetn,
    .br_valid, .br_req, .br_done, .br_rsp,
    .avl_address, .avl_byteenable, .avl_read, .avl_write, .avl_writedata,
    .avl_waitrequest, .avl_readdata, .avl_readdatavalid,
    .avl_writeresponsevalid, .avl_response
  );

  avl_ram_slave u_ram (
    .m_avl_hclk, .m_avl_hresetn,
    .avl_address, .avl_byteenable, .avl_read, .avl_write, .avl_writedata,
    .avl_waitrequest, .avl_readdata, .avl_readdatavalid,
    .avl_writeresponsevalid, .avl_response
  );

endmodule

/* rtl/avl_ram_slave.sv */
`timescale 1ns/1ps

module avl_ram_slave (
  input  logic        m_avl_hclk,
  input  logic        m_avl_hresetn,
  input  logic [31:0] avl_address,
  input  logic [3:0]  avl_byteenable,
  input  logic        avl_read,
  input  logic        avl_write,
  input  logic [31:0] avl_writedata,
  output logic        avl_waitrequest,
  output logic [31:0] avl_readdata,
  output logic        avl_readdatavalid,
  output logic        avl_writeresponsevalid,
  output logic [1:0]  avl_response
);

  logic [31:0]                   mem [avl_pkg::MEM_WORDS];
  logic [1:0]                    wait_cnt;
  logic [1:0]                    wait_need;
  logic                          cmd;
  logic                          accept;
  logic                          in_range;
  logic [avl_pkg::MEM_IDX_W-1:0] idx;

  initial begin
    for (int i = 0; i < avl_pkg::MEM_WORDS; i++) begin
      mem[i] = 32'd0;
    end
  end

  // Address bits 3:2 pick up to two wait states
  assign wait_need = (avl_address[3:2] == 2'd3) ? 2'd2 : avl_address[3:2];

  assign cmd             = avl_read || avl_write;
  assign avl_waitrequest = cmd && (wait_cnt != wait_need);
  assign accept          = cmd && !avl_waitrequest;
  assign in_range        = avl_address < 32'(avl_pkg::MEM_WORDS * 4);
  assign idx             = avl_address[avl_pkg::MEM_IDX_W+1:2];

  always_ff @(posedge m_avl_hclk) begin
    if (!m_avl_hresetn) begin
      wait_cnt               <= 2'd0;
      avl_readdatavalid      <= 1'b0;
      avl_writeresponsevalid <= 1'b0;
    end else begin
      avl_readdatavalid      <= accept && avl_read;
      avl_writeresponsevalid <= accept && avl_write;
      if (accept) begin
        wait_cnt <= 2'd0;
      end else if (avl_waitrequest) begin
        wait_cnt <= wait_cnt + 2'd1;
      end
    end
  end

  always_ff @(posedge m_avl_hclk) begin
    if (accept) begin
      avl_response <= in_range ? avl_pkg::AVL_RESP_OK : avl_pkg::AVL_RESP_SLVERR;
      avl_readdata <= (avl_read && in_range) ? mem[idx] : 32'd0;
    end
  end

  // Out of range writes are dropped
  always_ff @(posedge m_avl_hclk) begin
    if (accept && avl_write && in_range) begin
      for (int b = 0; b < 4; b++) begin
        if (avl_byteenable[b]) mem[idx][8*b +: 8] <= avl_writedata[8*b +: 8];
      end
    end
  end

  // The wait-state count relies on the master holding its command unchanged
  a_cmd_hold: assert property (@(posedge m_avl_hclk) disable iff (!m_avl_hresetn)
    avl_waitrequest |=> $stable({avl_read, avl_write, avl_address, avl_byteenable,
                                 avl_writedata}));

endmodule

/* rtl/avl_bridge.sv */
`timescale 1ns/1ps

module avl_bridge (
  input  logic                m_avl_hclk,
  input  logic                m_avl_hresetn,
  input  logic                br_valid,
  input  avl_pkg::mem_req_t   br_req,
  output logic                br_done,
  output avl_pkg::mem_rsp_t   br_rsp,
  output logic [31:0]         avl_address,
  output logic [3:0]          avl_byteenable,
  output logic                avl_read,
  output logic                avl_write,
  output logic [31:0]         avl_writedata,
  input  logic                avl_waitrequest,
  input  logic [31:0]         avl_readdata,
  input  logic                avl_readdatavalid,
  input  logic                avl_writeresponsevalid,
  input  logic [1:0]          avl_response
);

  avl_pkg::bridge_state_e state;
  avl_pkg::avl_cmd_e      cmd;
  logic                   start;
  logic                   accept;
  logic                   resp_seen;
  logic                   resp_ok;

  // br_valid is still high in the done cycle, so it must not restart the bridge
  assign start     = (state == avl_pkg::BR_IDLE) && br_valid && !br_done;
  assign avl_read  = (state == avl_pkg::BR_CMD) && (cmd == avl_pkg::CMD_READ);
  assign avl_write = (state == avl_pkg::BR_CMD) && (cmd == avl_pkg::CMD_WRITE);
  assign accept    = (avl_read || avl_write) && !avl_waitrequest;
  assign resp_ok   = (avl_response == avl_pkg::AVL_RESP_OK);
  assign resp_seen = ((cmd == avl_pkg::CMD_READ) && avl_readdatavalid) ||
                     ((cmd == avl_pkg::CMD_WRITE) && avl_writeresponsevalid);

  always_ff @(posedge m_avl_hclk) begin
    if (start) begin
      avl_address    <= br_req.addr;
      avl_byteenable <= br_req.strb;
      avl_writedata  <= br_req.wdata;
    end
    if (state == avl_pkg::BR_RESP && resp_seen) begin
      br_rsp.err   <= !resp_ok;
      br_rsp.rdata <= (cmd == avl_pkg::CMD_READ && resp_ok) ? avl_readdata : 32'd0;
    end
  end

  always_ff @(posedge m_avl_hclk) begin
    if (!m_avl_hresetn) begin
      state   <= avl_pkg::BR_IDLE;
      cmd     <= avl_pkg::CMD_IDLE;
      br_done <= 1'b0;
    end else begin
      br_done <= 1'b0;
      case (state)
        avl_pkg::BR_IDLE: if (start) begin
          cmd   <= (|br_req.strb) ? avl_pkg::CMD_WRITE : avl_pkg::CMD_READ;
          state <= avl_pkg::BR_CMD;
        end
        avl_pkg::BR_CMD: if (accept) state <= avl_pkg::BR_RESP;
        avl_pkg::BR_RESP: if (resp_seen) begin
          br_done <= 1'b1; // Errors complete the transfer too
          cmd     <= avl_pkg::CMD_IDLE;
          state   <= avl_pkg::BR_IDLE;
        end
        default: state <= avl_pkg::BR_IDLE;
      endcase
    end
  end

  a_rd_wr_excl: assert property (@(posedge m_avl_hclk) disable iff (!m_avl_hresetn)
    !(avl_read && avl_write));

  a_addr_hold: assert property (@(posedge m_avl_hclk) disable iff (!m_avl_hresetn)
    (avl_read || avl_write) && avl_waitrequest |=> $stable(avl_address));

endmodule

/* rtl/mem_port_arbiter.sv */
`timescale 1ns/1ps

module mem_port_arbiter (
  input  logic               m_avl_hclk,
  input  logic               m_avl_hresetn,
  input  logic               ifetch_valid,
  input  logic [31:0]        ifetch_addr,
  output logic               ifetch_done,
  output avl_pkg::mem_rsp_t  ifetch_rsp,
  input  logic               data_valid,
  input  avl_pkg::mem_req_t  data_req,
  output logic               data_done,
  output avl_pkg::mem_rsp_t  data_rsp,
  output logic               br_valid,
  output avl_pkg::mem_req_t  br_req,
  input  logic               br_done,
  input  avl_pkg::mem_rsp_t  br_rsp
);

  logic              busy;
  logic              owner_data;  // Set while the data port holds the grant
  logic              last_data;   // Set when the data port was served last
  logic              pick_data;
  avl_pkg::mem_req_t ifetch_req;

  // Instruction fetches are always reads
  always_comb begin
    ifetch_req       = '0;
    ifetch_req.addr  = ifetch_addr;
    ifetch_req.instr = 1'b1;
  end

  // The port that was not served last wins a tie
  assign pick_data = data_valid && (!ifetch_valid || !last_data);

  always_ff @(posedge m_avl_hclk) begin
    if (!m_avl_hresetn) begin
      busy       <= 1'b0;
      owner_data <= 1'b0;
      last_data  <= 1'b0;
    end else if (!busy) begin
      if (ifetch_valid || data_valid) begin
        busy       <= 1'b1;
        owner_data <= pick_data;
        last_data  <= pick_data;
      end
    end else if (br_done) begin
      busy <= 1'b0; // Clients drop valid or show a new request next cycle
    end
  end

  assign br_valid = busy;
  assign br_req   = owner_data ? data_req : ifetch_req;

  assign ifetch_done = br_done && busy && !owner_data;
  assign data_done   = br_done && busy && owner_data;
  assign ifetch_rsp  = owner_data ? '0 : br_rsp;
  assign data_rsp    = owner_data ? br_rsp : '0;

  // Only one client may ever see its transfer complete per cycle
  a_one_done: assert property (@(posedge m_avl_hclk) disable iff (!m_avl_hresetn)
    !(ifetch_done && data_done));

endmodule

/* rtl/avl_pkg.sv */
package avl_pkg;

  // Slave memory size in 32-bit words
  localparam int MEM_WORDS = 256;
  localparam int MEM_IDX_W = $clog2(MEM_WORDS);

  // Avalon response codes
  localparam logic [1:0] AVL_RESP_OK     = 2'd0;
  localparam logic [1:0] AVL_RESP_SLVERR = 2'd2;

  // A zero strobe means a read
  typedef struct packed {
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [3:0]  strb;
    logic        instr;
  } mem_req_t;

  typedef struct packed {
    logic [31:0] rdata;
    logic        err;
  } mem_rsp_t;

  typedef enum logic [1:0] {
    CMD_IDLE,
    CMD_READ,
    CMD_WRITE
  } avl_cmd_e;

  typedef enum logic [1:0] {
    BR_IDLE,
    BR_CMD,
    BR_RESP
  } bridge_state_e;

endpackage
